/* rtl/oq_macros.svh */
/*
 * Output queue stage sizes
 * Bus widths, queue count, region and FIFO depths, header marker
 */

`ifndef OQ_MACROS_SVH
`define OQ_MACROS_SVH

// Bus word is control byte plus data word
`define OQ_DATA_W     64
`define OQ_CTRL_W     8

// Queues and output ports, one to one
`define OQ_NUM_Q      4

// Words per queue region, so at most 63 data words per packet
`define OQ_Q_DEPTH    64

// Input FIFO entries
`define OQ_FIFO_DEPTH 8

// Control value of a module header word
`define OQ_HDR_CTRL   8'hff

`endif

/* rtl/oq_pkg.sv */
/*
 * Output queue types
 * Bus word, module header view and queue index, offset and address types
 */

`include "oq_macros.svh"

package oq_pkg;

   // Module header data word, high bits first
   typedef struct packed {
      logic [15:0] dst_ports;
      logic [15:0] word_len;
      logic [15:0] src_port;
      logic [15:0] byte_len;
   } oq_hdr_t;

   // Header words are moved as raw and decoded as hdr
   typedef union packed {
      logic [`OQ_DATA_W-1:0] raw;
      oq_hdr_t               hdr;
   } oq_data_u;

   typedef struct packed {
      logic [`OQ_CTRL_W-1:0] ctrl;
      oq_data_u              data;
   } oq_word_t;

   typedef logic [$clog2(`OQ_NUM_Q)-1:0]   q_idx_t;
   typedef logic [$clog2(`OQ_Q_DEPTH)-1:0] q_ptr_t;

   // Counts 0 to depth inclusive
   typedef logic [$clog2(`OQ_Q_DEPTH):0]   q_space_t;

   // Queue number selects the region, offset the word inside it
   typedef struct packed {
      q_idx_t q;
      q_ptr_t off;
   } buf_addr_t;

endpackage

/* rtl/oq_input_fifo.sv */
/*
 * Input FIFO
 * Small fall-through buffer between the input bus and the store machine
 */

`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_input_fifo import oq_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  oq_word_t in_word,
   input  logic     in_valid,
   output logic     in_ready,
   output oq_word_t fifo_head,
   output logic     fifo_empty,
   input  logic     fifo_pop
);

   localparam int IDX_W = $clog2(`OQ_FIFO_DEPTH);

   oq_word_t         mem [`OQ_FIFO_DEPTH];
   logic [IDX_W-1:0] wr_idx;
   logic [IDX_W-1:0] rd_idx;
   logic [IDX_W:0]   count;
   logic [IDX_W:0]   count_nxt;
   logic             push;
   logic             pop;

   assign push = in_valid && in_ready;
   assign pop  = fifo_pop && !fifo_empty;

   always_comb begin
      count_nxt = count;
      if (push && !pop) begin
         count_nxt = count + 1'b1;
      end else if (pop && !push) begin
         count_nxt = count - 1'b1;
      end
   end

   // Ready registered from next occupancy, low through reset
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_idx   <= '0;
         rd_idx   <= '0;
         count    <= '0;
         in_ready <= 1'b0;
      end else begin
         if (push) wr_idx <= wr_idx + 1'b1;
         if (pop)  rd_idx <= rd_idx + 1'b1;
         count    <= count_nxt;
         in_ready <= count_nxt < (IDX_W+1)'(`OQ_FIFO_DEPTH);
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[wr_idx] <= in_word;
   end

   assign fifo_head  = mem[rd_idx];
   assign fifo_empty = (count == '0);

endmodule

/* rtl/oq_store_fsm.sv */
/*
 * Store machine
 * Parses each module header, picks the queue, stores or drops the packet
 */

`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_store_fsm import oq_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  oq_word_t fifo_head,
   input  logic     fifo_empty,
   output logic     fifo_pop,
   input  q_space_t free_space [`OQ_NUM_Q],
   output logic     wr_en,
   output q_idx_t   wr_q,
   output oq_word_t wr_word,
   output logic     pkt_stored
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DECIDE,
      ST_STORE,
      ST_DISCARD
   } st_t;

   st_t         state;
   logic [15:0] cnt;
   q_idx_t      sel_q;
   logic        hit;
   logic [16:0] need;
   logic        fits;

   // ******************************************************************
   // Header decode
   // ******************************************************************

   // Lowest set destination bit wins
   always_comb begin
      hit   = 1'b0;
      sel_q = '0;
      for (int i = 0; i < `OQ_NUM_Q; i++) begin
         if (!hit && fifo_head.data.hdr.dst_ports[i]) begin
            sel_q = q_idx_t'(i);
            hit   = 1'b1;
         end
      end
   end

   // Header plus word_len data words must fit at once
   assign need = 17'(fifo_head.data.hdr.word_len) + 17'd1;
   assign fits = need <= 17'(free_space[sel_q]);

   // ******************************************************************
   // Control
   // ******************************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
         cnt   <= '0;
         wr_q  <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               // Stray non-header words are popped below
               if (!fifo_empty && fifo_head.ctrl == `OQ_HDR_CTRL) begin
                  state <= ST_DECIDE;
               end
            end
            ST_DECIDE: begin
               wr_q  <= sel_q;
               cnt   <= fifo_head.data.hdr.word_len;
               state <= (hit && fits) ? ST_STORE : ST_DISCARD;
            end
            ST_STORE, ST_DISCARD: begin
               if (!fifo_empty) begin
                  if (cnt == '0) begin
                     state <= ST_IDLE;
                  end else begin
                     cnt <= cnt - 1'b1;
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_comb begin
      fifo_pop = 1'b0;
      case (state)
         ST_IDLE:              fifo_pop = !fifo_empty && fifo_head.ctrl != `OQ_HDR_CTRL;
         ST_STORE, ST_DISCARD: fifo_pop = !fifo_empty;
         default:              fifo_pop = 1'b0;
      endcase
   end

   assign wr_en      = (state == ST_STORE) && !fifo_empty;
   assign wr_word    = fifo_head;
   // Last word write closes the packet
   assign pkt_stored = wr_en && (cnt == '0);

endmodule

/* rtl/oq_queue_ptrs.sv */
/*
 * Queue pointers
 * Per-queue write and read pointers, packet counts and free space
 */

`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_queue_ptrs import oq_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      wr_en,
   input  q_idx_t    wr_q,
   input  logic      pkt_stored,
   input  logic      rd_en,
   input  q_idx_t    rd_q,
   input  logic      pkt_taken,
   output buf_addr_t wr_addr,
   output buf_addr_t rd_addr,
   output q_space_t  free_space [`OQ_NUM_Q],
   output logic [`OQ_NUM_Q-1:0] pkt_avail
);

   // Pointers carry one wrap bit above the offset
   localparam int PTR_W = $bits(q_ptr_t) + 1;

   q_ptr_t wr_off [`OQ_NUM_Q];
   q_ptr_t rd_off [`OQ_NUM_Q];

   for (genvar q = 0; q < `OQ_NUM_Q; q++) begin : g_q
      logic [PTR_W-1:0] wr_ptr;
      logic [PTR_W-1:0] rd_ptr;
      q_space_t         pkt_cnt;
      logic             wr_hit;
      logic             rd_hit;
      logic             st_hit;
      logic             tk_hit;

      assign wr_hit = wr_en      && (wr_q == q_idx_t'(q));
      assign rd_hit = rd_en      && (rd_q == q_idx_t'(q));
      assign st_hit = pkt_stored && (wr_q == q_idx_t'(q));
      assign tk_hit = pkt_taken  && (rd_q == q_idx_t'(q));

      always_ff @(posedge clk) begin
         if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            pkt_cnt <= '0;
         end else begin
            if (wr_hit) wr_ptr <= wr_ptr + 1'b1;
            if (rd_hit) rd_ptr <= rd_ptr + 1'b1;
            // Store and take may land in the same cycle
            if (st_hit && !tk_hit) begin
               pkt_cnt <= pkt_cnt + 1'b1;
            end else if (tk_hit && !st_hit) begin
               pkt_cnt <= pkt_cnt - 1'b1;
            end
         end
      end

      assign wr_off[q] = q_ptr_t'(wr_ptr);
      assign rd_off[q] = q_ptr_t'(rd_ptr);

      // Words of a partly stored packet already count as used
      assign free_space[q] = q_space_t'(`OQ_Q_DEPTH) - q_space_t'(wr_ptr - rd_ptr);
      assign pkt_avail[q]  = (pkt_cnt != '0);
   end

   assign wr_addr = {wr_q, wr_off[wr_q]};
   assign rd_addr = {rd_q, rd_off[rd_q]};

endmodule

/* rtl/oq_pkt_buffer.sv */
/*
 * Packet buffer
 * One region per queue, one write port and one registered read port
 */

`timescale 1ns/1ps

module oq_pkt_buffer import oq_pkg::*; (
   input  logic      clk,
   input  logic      wr_en,
   input  buf_addr_t wr_addr,
   input  oq_word_t  wr_word,
   input  logic      rd_en,
   input  buf_addr_t rd_addr,
   output oq_word_t  rd_word
);

   localparam int DEPTH = 2 ** $bits(buf_addr_t);

   oq_word_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en) mem[wr_addr] <= wr_word;
   end

   // Read data one cycle after the request
   always_ff @(posedge clk) begin
      if (rd_en) rd_word <= mem[rd_addr];
   end

endmodule

/* rtl/oq_remove.sv */
/*
 * Packet remover
 * Round-robin over queues with packets, sends each whole packet on its port
 */

`timescale 1ns/1ps
`include "oq_macros.svh"

module oq_remove import oq_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [`OQ_NUM_Q-1:0] pkt_avail,
   output logic                 rd_en,
   output q_idx_t               rd_q,
   output logic                 pkt_taken,
   input  oq_word_t             rd_word,
   output oq_word_t             out_word [`OQ_NUM_Q],
   output logic [`OQ_NUM_Q-1:0] out_valid,
   input  logic [`OQ_NUM_Q-1:0] out_ready
);

   typedef enum logic [1:0] {
      RM_IDLE,
      RM_WAIT,
      RM_SEND
   } rm_t;

   rm_t         state;
   q_idx_t      last_q;
   q_idx_t      cur_q;
   q_idx_t      sel_q;
   q_idx_t      cand;
   logic        any_avail;
   logic        is_hdr;
   logic [15:0] cnt;
   logic        valid_r;
   oq_word_t    out_reg;

   // ******************************************************************
   // Round-robin pick, starting after the last queue served
   // ******************************************************************

   always_comb begin
      any_avail = 1'b0;
      sel_q     = last_q;
      cand      = last_q;
      for (int i = 1; i <= `OQ_NUM_Q; i++) begin
         cand = last_q + q_idx_t'(i);
         if (!any_avail && pkt_avail[cand]) begin
            sel_q     = cand;
            any_avail = 1'b1;
         end
      end
   end

   // ******************************************************************
   // Read and send
   // ******************************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= RM_IDLE;
         last_q  <= q_idx_t'(`OQ_NUM_Q - 1);
         cur_q   <= '0;
         is_hdr  <= 1'b0;
         cnt     <= '0;
         valid_r <= 1'b0;
      end else begin
         case (state)
            RM_IDLE: begin
               if (any_avail) begin
                  cur_q  <= sel_q;
                  is_hdr <= 1'b1;
                  state  <= RM_WAIT;
               end
            end
            RM_WAIT: begin
               // Header gives the data word count
               if (is_hdr) cnt <= rd_word.data.hdr.word_len;
               is_hdr  <= 1'b0;
               valid_r <= 1'b1;
               state   <= RM_SEND;
            end
            RM_SEND: begin
               if (out_ready[cur_q]) begin
                  valid_r <= 1'b0;
                  if (cnt == '0) begin
                     last_q <= cur_q;
                     state  <= RM_IDLE;
                  end else begin
                     cnt   <= cnt - 1'b1;
                     state <= RM_WAIT;
                  end
               end
            end
            default: state <= RM_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == RM_WAIT) out_reg <= rd_word;
   end

   // Next read only once the held word has gone
   assign pkt_taken = (state == RM_IDLE) && any_avail;
   assign rd_en     = pkt_taken ||
                      ((state == RM_SEND) && out_ready[cur_q] && (cnt != '0));
   assign rd_q      = (state == RM_IDLE) ? sel_q : cur_q;

   for (genvar p = 0; p < `OQ_NUM_Q; p++) begin : g_port
      assign out_word[p]  = out_reg;
      assign out_valid[p] = valid_r && (cur_q == q_idx_t'(p));
   end

endmodule

/* rtl/output_queues.sv */
/*
 * Output queues
 * Input FIFO, store machine, queue pointers, packet buffer and remover
 */

`timescale 1ns/1ps
`include "oq_macros.svh"

module output_queues import oq_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  oq_word_t             in_word,
   input  logic                 in_valid,
   output logic                 in_ready,
   output oq_word_t             out_word [`OQ_NUM_Q],
   output logic [`OQ_NUM_Q-1:0] out_valid,
   input  logic [`OQ_NUM_Q-1:0] out_ready
);

   oq_word_t             fifo_head;
   logic                 fifo_empty;
   logic                 fifo_pop;
   q_space_t             free_space [`OQ_NUM_Q];
   logic                 wr_en;
   q_idx_t               wr_q;
   oq_word_t             wr_word;
   logic                 pkt_stored;
   buf_addr_t            wr_addr;
   logic                 rd_en;
   q_idx_t               rd_q;
   logic                 pkt_taken;
   buf_addr_t            rd_addr;
   oq_word_t             rd_word;
   logic [`OQ_NUM_Q-1:0] pkt_avail;

   // ******************************************************************
   // Store side
   // ******************************************************************

   oq_input_fifo u_fifo (
      .clk(clk), .rst(rst),
      .in_word(in_word), .in_valid(in_valid), .in_ready(in_ready),
      .fifo_head(fifo_head), .fifo_empty(fifo_empty), .fifo_pop(fifo_pop)
   );

   oq_store_fsm u_store (
      .clk(clk), .rst(rst),
      .fifo_head(fifo_head), .fifo_empty(fifo_empty), .fifo_pop(fifo_pop),
      .free_space(free_space),
      .wr_en(wr_en), .wr_q(wr_q), .wr_word(wr_word), .pkt_stored(pkt_stored)
   );

   // ******************************************************************
   // Queue state and memory
   // ******************************************************************

   oq_queue_ptrs u_ptrs (
      .clk(clk), .rst(rst),
      .wr_en(wr_en), .wr_q(wr_q), .pkt_stored(pkt_stored),
      .rd_en(rd_en), .rd_q(rd_q), .pkt_taken(pkt_taken),
      .wr_addr(wr_addr), .rd_addr(rd_addr),
      .free_space(free_space), .pkt_avail(pkt_avail)
   );

   oq_pkt_buffer u_buf (
      .clk(clk),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_word(wr_word),
      .rd_en(rd_en), .rd_addr(rd_addr), .rd_word(rd_word)
   );

   // Remove side
   oq_remove u_remove (
      .clk(clk), .rst(rst),
      .pkt_avail(pkt_avail),
      .rd_en(rd_en), .rd_q(rd_q), .pkt_taken(pkt_taken), .rd_word(rd_word),
      .out_word(out_word), .out_valid(out_valid), .out_ready(out_ready)
   );

endmodule

/* tests/output_queues_chk.sv */
/*
 * Output handshake checker
 * Concurrent assertions on the output ports of the output queue stage
 */

`timescale 1ns/1ps
`include "oq_macros.svh"

module output_queues_chk import oq_pkg::*; (
   input logic                 clk,
   input logic                 rst,
   input oq_word_t             out_word [`OQ_NUM_Q],
   input logic [`OQ_NUM_Q-1:0] out_valid,
   input logic [`OQ_NUM_Q-1:0] out_ready
);

   bit                   rst_bad   = 1'b0;
   bit                   multi_bad = 1'b0;
   logic [`OQ_NUM_Q-1:0] hold_bad;
   logic                 failed;

   // Reset clears every port
   a_idle_after_rst: assert property (@(posedge clk) rst |=> (out_valid == '0))
      else begin
         $error("out_valid high in the cycle after reset");
         rst_bad = 1'b1;
      end

   // Single remover, so one port at a time
   a_one_valid: assert property (@(posedge clk) disable iff (rst) $onehot0(out_valid))
      else begin
         $error("more than one out_valid high");
         multi_bad = 1'b1;
      end

   for (genvar p = 0; p < `OQ_NUM_Q; p++) begin : g_port
      bit bad = 1'b0;

      // Held word must not move until taken
      a_word_held: assert property (@(posedge clk) disable iff (rst)
         (out_valid[p] && !out_ready[p]) |=> (out_valid[p] && $stable(out_word[p])))
         else begin
            $error("port %0d dropped or changed a word before the transfer", p);
            bad = 1'b1;
         end

      assign hold_bad[p] = bad;
   end

   assign failed = rst_bad || multi_bad || (hold_bad != '0);

endmodule

/* tests/output_queues_tb.sv */
/*
 * Output queues testbench
 * Table-driven packets, free space reference model, random back-pressure
 */

`timescale 1ns/1ps
`include "oq_macros.svh"

module output_queues_tb import oq_pkg::*;;

   localparam int READY_TIMEOUT = 20;
   localparam int SEND_TIMEOUT  = 200;
   localparam int DRAIN_TIMEOUT = 5000;
   localparam int NUM_PKTS      = 29;

   typedef struct packed {
      logic [15:0] dst;
      logic [15:0] len;
      int          port;
      int          phase;
   } pkt_row_t;

   // ******************************************************************
   // Packet table
   // port is the expected output port or -1 for a drop
   // phase 1 holds port 1 not ready
   // ******************************************************************

   localparam pkt_row_t PKTS [NUM_PKTS] = '{
      // Single and multi bit destinations, zero and out of range fields
      '{16'h0001, 16'd3,  0, 0},
      '{16'h0002, 16'd0,  1, 0},
      '{16'h0004, 16'd5,  2, 0},
      '{16'h0008, 16'd2,  3, 0},
      '{16'h000c, 16'd4,  2, 0},
      '{16'h000a, 16'd1,  1, 0},
      '{16'h0000, 16'd2, -1, 0},
      '{16'h0010, 16'd1, -1, 0},
      '{16'h0007, 16'd6,  0, 0},
      // Port 1 stalled until its region fills
      '{16'h0002, 16'd20, 1, 1},
      '{16'h0002, 16'd20, 1, 1},
      '{16'h0002, 16'd20, 1, 1},
      '{16'h0002, 16'd10, -1, 1},
      '{16'h0001, 16'd5,  0, 1},
      '{16'h0002, 16'd0,  1, 1},
      '{16'h0002, 16'd5, -1, 1},
      // Interleaved over all queues
      '{16'h0001, 16'd7,  0, 2},
      '{16'h0002, 16'd4,  1, 2},
      '{16'h0004, 16'd0,  2, 2},
      '{16'h0008, 16'd6,  3, 2},
      '{16'h0006, 16'd2,  1, 2},
      '{16'h0008, 16'd1,  3, 2},
      '{16'h0001, 16'd5,  0, 2},
      '{16'h000f, 16'd3,  0, 2},
      '{16'h0004, 16'd7,  2, 2},
      '{16'h0002, 16'd2,  1, 2},
      '{16'h0000, 16'd3, -1, 2},
      '{16'h000c, 16'd5,  2, 2},
      '{16'h0008, 16'd0,  3, 2}
   };

   logic                 clk       = 1'b0;
   logic                 rst       = 1'b1;
   oq_word_t             in_word   = '0;
   logic                 in_valid  = 1'b0;
   logic                 in_ready;
   oq_word_t             out_word [`OQ_NUM_Q];
   logic [`OQ_NUM_Q-1:0] out_valid;
   logic [`OQ_NUM_Q-1:0] out_ready = '0;

   logic [31:0] rng  = 32'h610d_24ee;
   logic        hold = 1'b0;
   oq_word_t    exp_words [`OQ_NUM_Q][$];
   int          used [`OQ_NUM_Q];

   always #10 clk = ~clk;

   output_queues UUT (
      .clk(clk), .rst(rst),
      .in_word(in_word), .in_valid(in_valid), .in_ready(in_ready),
      .out_word(out_word), .out_valid(out_valid), .out_ready(out_ready)
   );

   bind output_queues output_queues_chk chk (
      .clk(clk), .rst(rst),
      .out_word(out_word), .out_valid(out_valid), .out_ready(out_ready)
   );

   function automatic logic [31:0] xorshift(logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] rand_word();
      rng = xorshift(rng);
      return rng;
   endfunction

   task automatic stop_run(string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_word(string name, oq_word_t got, oq_word_t exp);
      if (got !== exp) begin
         stop_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_qidx(string name, q_idx_t got, q_idx_t exp);
      if (got !== exp) begin
         stop_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         stop_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   // ******************************************************************
   // One cycle: sample outputs, pick out_ready, score transfers
   // ******************************************************************

   task automatic tick();
      logic [31:0]          r;
      logic [`OQ_NUM_Q-1:0] rdy;
      oq_word_t             w;
      @(negedge clk);
      if (UUT.chk.failed) stop_run("Output handshake assertion failed in the bound checker");
      r = rand_word();
      for (int p = 0; p < `OQ_NUM_Q; p++) begin
         rdy[p] = ((r >> (2 * p)) & 32'h3) != 0;
         if (hold && p == 1) rdy[p] = 1'b0;
      end
      out_ready = rdy;
      for (int p = 0; p < `OQ_NUM_Q; p++) begin
         if (out_valid[p] && rdy[p]) begin
            // Header source field indexes the packet table
            if (out_word[p].ctrl == `OQ_HDR_CTRL &&
                int'(out_word[p].data.hdr.src_port) < NUM_PKTS) begin
               check_qidx("header output port", q_idx_t'(p),
                          q_idx_t'(PKTS[out_word[p].data.hdr.src_port].port));
            end
            if (exp_words[p].size() == 0) begin
               stop_run($sformatf("Port %0d sent a word that no kept packet explains", p));
            end
            w = exp_words[p].pop_front();
            check_word($sformatf("out_word[%0d]", p), out_word[p], w);
            used[p]--;
         end
      end
   endtask

   task automatic send_word(oq_word_t w);
      int n;
      n = 0;
      tick();
      while (!in_ready) begin
         in_valid = 1'b0;
         n++;
         if (n > SEND_TIMEOUT) stop_run("Timeout waiting for in_ready");
         tick();
      end
      in_word  = w;
      in_valid = 1'b1;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_words[0].size() + exp_words[1].size() +
             exp_words[2].size() + exp_words[3].size() != 0) begin
         n++;
         if (n > DRAIN_TIMEOUT) stop_run("Timeout waiting for kept packets to leave");
         tick();
      end
   endtask

   task automatic send_packet(int idx);
      pkt_row_t  row;
      oq_word_t  pkt [$];
      oq_word_t  w;
      q_idx_t    q;
      logic      hit;
      int        want;
      row  = PKTS[idx];
      hit  = 1'b0;
      q    = '0;
      want = -1;
      // Lowest set destination bit, then room for header plus data
      for (int b = 0; b < `OQ_NUM_Q; b++) begin
         if (!hit && row.dst[b]) begin
            q   = q_idx_t'(b);
            hit = 1'b1;
         end
      end
      if (hit && int'(row.len) + 1 <= `OQ_Q_DEPTH - used[q]) want = int'(q);
      if (want != row.port) begin
         stop_run($sformatf("Packet %0d listed for port %0d but free space gives %0d",
                            idx, row.port, want));
      end
      w.ctrl               = `OQ_HDR_CTRL;
      w.data.hdr.dst_ports = row.dst;
      w.data.hdr.word_len  = row.len;
      w.data.hdr.src_port  = 16'(idx);
      w.data.hdr.byte_len  = row.len * 16'd8;
      pkt.push_back(w);
      for (int k = 0; k < int'(row.len); k++) begin
         w.ctrl          = 8'(rand_word() & 32'h7f);
         w.data.raw[63:32] = rand_word();
         w.data.raw[31:0]  = rand_word();
         pkt.push_back(w);
      end
      if (want >= 0) begin
         foreach (pkt[k]) exp_words[q].push_back(pkt[k]);
         used[q] += pkt.size();
      end
      foreach (pkt[k]) send_word(pkt[k]);
      tick();
      in_valid = 1'b0;
   endtask

   initial begin
      int n;
      int cur_phase;
      cur_phase = -1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      check_bit("in_ready", in_ready, 1'b0);
      for (int p = 0; p < `OQ_NUM_Q; p++) begin
         check_bit($sformatf("out_valid[%0d]", p), out_valid[p], 1'b0);
      end
      rst = 1'b0;
      n   = 0;
      while (!in_ready) begin
         n++;
         if (n > READY_TIMEOUT) stop_run("in_ready did not rise after reset");
         tick();
      end

      for (int i = 0; i < NUM_PKTS; i++) begin
         if (PKTS[i].phase != cur_phase) begin
            // Let the store side finish before the hold changes
            repeat (8) tick();
            hold = 1'b0;
            wait_drain();
            hold      = (PKTS[i].phase == 1);
            cur_phase = PKTS[i].phase;
         end
         send_packet(i);
      end

      repeat (8) tick();
      hold = 1'b0;
      wait_drain();
      // Quiet period catches words from dropped packets
      repeat (40) tick();
      $display("No errors");
      $finish;
   end

endmodule

/* output_queues.f */
+incdir+rtl
rtl/oq_pkg.sv
rtl/oq_input_fifo.sv
rtl/oq_store_fsm.sv
rtl/oq_queue_ptrs.sv
rtl/oq_pkt_buffer.sv
rtl/oq_remove.sv
rtl/output_queues.sv
tests/output_queues_chk.sv
tests/output_queues_tb.sv
